//--- ExLuMul3Ra8.sv
`timescale 1ns/1ns
`default_nettype none

module ExLuMul3Ra8
(
	input  wire  [mulPkg::DigitW-1:0]   valA,
	input  wire  [mulPkg::DigitW-1:0]   valB,
	output logic [mulPkg::PartialW-1:0] valC
);

	always_comb
	begin
		case ({valA, valB})  // full table, one row per digit of A.
			6'b000_000: valC = 6'b000000;
			6'b000_001: valC = 6'b000000;
			6'b000_010: valC = 6'b000000;
			6'b000_011: valC = 6'b000000;
			6'b000_100: valC = 6'b000000;
			6'b000_101: valC = 6'b000000;
			6'b000_110: valC = 6'b000000;
			6'b000_111: valC = 6'b000000;

			6'b001_000: valC = 6'b000000;
			6'b001_001: valC = 6'b000001;
			6'b001_010: valC = 6'b000010;
			6'b001_011: valC = 6'b000011;
			6'b001_100: valC = 6'b000100;
			6'b001_101: valC = 6'b000101;
			6'b001_110: valC = 6'b000110;
			6'b001_111: valC = 6'b000111;

			6'b010_000: valC = 6'b000000;
			6'b010_001: valC = 6'b000010;
			6'b010_010: valC = 6'b000100;
			6'b010_011: valC = 6'b000110;
			6'b010_100: valC = 6'b001000;
			6'b010_101: valC = 6'b001010;
			6'b010_110: valC = 6'b001100;
			6'b010_111: valC = 6'b001110;

			6'b011_000: valC = 6'b000000;
			6'b011_001: valC = 6'b000011;
			6'b011_010: valC = 6'b000110;
			6'b011_011: valC = 6'b001001;
			6'b011_100: valC = 6'b001100;
			6'b011_101: valC = 6'b001111;
			6'b011_110: valC = 6'b010010;
			6'b011_111: valC = 6'b010101;

			6'b100_000: valC = 6'b000000;
			6'b100_001: valC = 6'b000100;
			6'b100_010: valC = 6'b001000;
			6'b100_011: valC = 6'b001100;
			6'b100_100: valC = 6'b010000;
			6'b100_101: valC = 6'b010100;
			6'b100_110: valC = 6'b011000;
			6'b100_111: valC = 6'b011100;

			6'b101_000: valC = 6'b000000;
			6'b101_001: valC = 6'b000101;
			6'b101_010: valC = 6'b001010;
			6'b101_011: valC = 6'b001111;
			6'b101_100: valC = 6'b010100;
			6'b101_101: valC = 6'b011001;
			6'b101_110: valC = 6'b011110;
			6'b101_111: valC = 6'b100011;

			6'b110_000: valC = 6'b000000;
			6'b110_001: valC = 6'b000110;
			6'b110_010: valC = 6'b001100;
			6'b110_011: valC = 6'b010010;
			6'b110_100: valC = 6'b011000;
			6'b110_101: valC = 6'b011110;
			6'b110_110: valC = 6'b100100;
			6'b110_111: valC = 6'b101010;

			6'b111_000: valC = 6'b000000;
			6'b111_001: valC = 6'b000111;
			6'b111_010: valC = 6'b001110;
			6'b111_011: valC = 6'b010101;
			6'b111_100: valC = 6'b011100;
			6'b111_101: valC = 6'b100011;
			6'b111_110: valC = 6'b101010;
			6'b111_111: valC = 6'b110001;
		endcase
	end

endmodule

`default_nettype wire

//--- mulDigitStage.sv
`timescale 1ns/1ns
`default_nettype none

module mulDigitStage
(
	input  wire                       clock,
	input  wire                       arstN,
	input  wire                       opValid,
	input  wire mulPkg::mulOperand_t  opA,
	input  wire mulPkg::mulOperand_t  opB,
	output logic                      opReady,
	output logic                      ppValid,
	output mulPkg::mulPartials_t      pp,
	input  wire                       ppReady
);

	import mulPkg::*;

	mulPartials_t ppNext;
	logic         opTake;

	// slot frees up when empty or when its item leaves this cycle.
	assign opReady = ~ppValid | ppReady;
	assign opTake  = opValid & opReady;

	// one lookup per digit pair.
	for (genvar j = 0; j < NumDigits; j++)
	begin : gRow
		for (genvar i = 0; i < NumDigits; i++)
		begin : gCol
			ExLuMul3Ra8 uLut
			(
				.valA(opA.digit[i]),
				.valB(opB.digit[j]),
				.valC(ppNext[j][i])
			);
		end
	end

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
			ppValid <= 1'b0;
		else if (opReady)
			ppValid <= opValid;  // load or drain.
	end

	always_ff @(posedge clock)
	begin
		if (opTake)
			pp <= ppNext;
	end

	// held item must not change until the row stage takes it.
	ppHold: assert property (@(posedge clock) disable iff (!arstN)
		ppValid && !ppReady |=> ppValid && $stable(pp));

	ppKnown: assert property (@(posedge clock) disable iff (!arstN)
		!$isunknown(ppValid));

	// the whole operand words, not only their digits, must be defined.
	opKnown: assert property (@(posedge clock) disable iff (!arstN)
		opTake |-> !$isunknown({opA.value, opB.value}));

endmodule

`default_nettype wire

//--- mulFinalStage.sv
`timescale 1ns/1ns
`default_nettype none

module mulFinalStage
(
	input  wire                         clock,
	input  wire                         arstN,
	input  wire                         rowValid,
	input  wire mulPkg::mulRows_t       rows,
	output logic                        rowReady,
	output logic                        resValid,
	output logic [mulPkg::ProductW-1:0] product,
	input  wire                         resReady
);

	import mulPkg::*;

	logic [ProductW-1:0] sum;

	assign rowReady = ~resValid | resReady;

	always_comb
	begin
		sum = '0;
		for (int j = 0; j < NumDigits; j++)
			sum = sum + (ProductW'(rows[j]) << (DigitW * j));  // weight of digit j of B.
	end

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
			resValid <= 1'b0;
		else if (rowReady)
			resValid <= rowValid;
	end

	always_ff @(posedge clock)
	begin
		if (rowValid && rowReady)
			product <= sum;
	end

	resHold: assert property (@(posedge clock) disable iff (!arstN)
		resValid && !resReady |=> resValid && $stable(product));

endmodule

`default_nettype wire

//--- mulPkg.sv
`default_nettype none

package mulPkg;

	localparam int DigitW    = 3;  // one radix-8 digit.
	localparam int NumDigits = 4;
	localparam int OperandW  = DigitW * NumDigits;
	localparam int PartialW  = 2 * DigitW;  // digit times digit.
	localparam int RowW      = OperandW + DigitW;
	localparam int ProductW  = 2 * OperandW;

	// operand word, taken whole or as four digits (digit 0 is the low one).
	typedef union packed
	{
		logic [OperandW-1:0]                value;
		logic [NumDigits-1:0][DigitW-1:0]   digit;
	} mulOperand_t;

	// entry [j][i] is digit i of A times digit j of B.
	typedef logic [NumDigits-1:0][NumDigits-1:0][PartialW-1:0] mulPartials_t;

	// entry j is A times digit j of B.
	typedef logic [NumDigits-1:0][RowW-1:0] mulRows_t;

endpackage

`default_nettype wire

//--- mulRowStage.sv
`timescale 1ns/1ns
`default_nettype none

module mulRowStage
(
	input  wire                        clock,
	input  wire                        arstN,
	input  wire                        ppValid,
	input  wire mulPkg::mulPartials_t  pp,
	output logic                       ppReady,
	output logic                       rowValid,
	output mulPkg::mulRows_t           rows,
	input  wire                        rowReady
);

	import mulPkg::*;

	mulRows_t rowSum;

	assign ppReady = ~rowValid | rowReady;

	// row j is A times digit j of B.
	always_comb
	begin
		rowSum = '0;
		for (int j = 0; j < NumDigits; j++)
		begin
			for (int i = 0; i < NumDigits; i++)
			begin
				rowSum[j] = rowSum[j] + (RowW'(pp[j][i]) << (DigitW * i));
			end
		end
	end

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
			rowValid <= 1'b0;
		else if (ppReady)
			rowValid <= ppValid;
	end

	always_ff @(posedge clock)
	begin
		if (ppValid && ppReady)
			rows <= rowSum;
	end

	rowHold: assert property (@(posedge clock) disable iff (!arstN)
		rowValid && !rowReady |=> rowValid && $stable(rows));

endmodule

`default_nettype wire

//--- mulTop.sv
`timescale 1ns/1ns
`default_nettype none

module mulTop
(
	input  wire                         clock,
	input  wire                         arstN,
	input  wire                         opValid,
	input  wire  [mulPkg::OperandW-1:0] opA,
	input  wire  [mulPkg::OperandW-1:0] opB,
	output logic                        opReady,
	output logic                        resValid,
	output logic [mulPkg::ProductW-1:0] product,
	input  wire                         resReady
);

	import mulPkg::*;

	logic         ppValid;
	logic         ppReady;
	mulPartials_t pp;
	logic         rowValid;
	logic         rowReady;
	mulRows_t     rows;

	mulDigitStage uDigit
	(
		.clock   (clock),
		.arstN   (arstN),
		.opValid (opValid),
		.opA     (mulOperand_t'(opA)),
		.opB     (mulOperand_t'(opB)),
		.opReady (opReady),
		.ppValid (ppValid),
		.pp      (pp),
		.ppReady (ppReady)
	);

	mulRowStage uRow
	(
		.clock    (clock),
		.arstN    (arstN),
		.ppValid  (ppValid),
		.pp       (pp),
		.ppReady  (ppReady),
		.rowValid (rowValid),
		.rows     (rows),
		.rowReady (rowReady)
	);

	mulFinalStage uFinal
	(
		.clock    (clock),
		.arstN    (arstN),
		.rowValid (rowValid),
		.rows     (rows),
		.rowReady (rowReady),
		.resValid (resValid),
		.product  (product),
		.resReady (resReady)
	);

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# builds the multiplier testbench with Verilator and runs it.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "cannot enter the project directory"
	exit 1
fi

verilator --binary --timing --assert -f src.f --top-module tbMul -o simMul
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/simMul > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation finished: PASS" sim.log; then
	exit 0
fi
exit 1

//--- src.f
mulPkg.sv
ExLuMul3Ra8.sv
mulDigitStage.sv
mulRowStage.sv
mulFinalStage.sv
mulTop.sv
tbMul.sv

//--- tbMul.sv
`timescale 1ns/1ns
`default_nettype none

module tbMul;

	import mulPkg::*;

	localparam int ClockPeriod = 4;
	localparam int ResetCycles = 8;
	localparam int DrainLimit  = 200;
	localparam int TotalOps    = 2000 + 64 + 36 + 1000 + 50 + 300 + 6 + 25;

	logic                clock;
	logic                arstN;
	logic                opValid;
	logic [OperandW-1:0] opA;
	logic [OperandW-1:0] opB;
	logic                opReady;
	logic                resValid;
	logic [ProductW-1:0] product;
	logic                resReady;

	logic [31:0]         stimState;
	logic                randomReady;
	logic                checkLatency;
	logic                holding;
	logic [ProductW-1:0] heldProduct;
	logic [ProductW-1:0] expected[$];
	int                  acceptedAt[$];
	int                  cycle;
	int                  errors;
	int                  acceptCount;
	int                  resultCount;
	logic [OperandW-1:0] edgeVals[6];

	mulTop DUT
	(
		.clock    (clock),
		.arstN    (arstN),
		.opValid  (opValid),
		.opA      (opA),
		.opB      (opB),
		.opReady  (opReady),
		.resValid (resValid),
		.product  (product),
		.resReady (resReady)
	);

	// galois lfsr with taps x^32 + x^22 + x^2 + x + 1.
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic logic nextBit();
		stimState = lfsrStep(stimState);
		return stimState[0];
	endfunction

	function automatic logic [OperandW-1:0] randOperand();
		logic [OperandW-1:0] v;
		for (int k = 0; k < OperandW; k++)
			v[k] = nextBit();
		return v;
	endfunction

	task automatic logError(input string msg);
		errors++;
		$display("%s", msg);
	endtask

	// called just after a rising edge; returns just after the accepting edge.
	task automatic sendPair(input logic [OperandW-1:0] a, input logic [OperandW-1:0] b);
		logic taken;
		begin
			opValid = 1'b1;
			opA     = a;
			opB     = b;
			taken   = 1'b0;
			while (!taken)
			begin
				@(negedge clock);
				taken = opReady;
				if (checkLatency && opReady !== 1'b1)
					logError($sformatf("CHECK FAILED opReady expected %h actual %h", 1'b1, opReady));
				@(posedge clock);
				#1;
			end
		end
	endtask

	task automatic idleCycles(input int n);
		opValid = 1'b0;
		repeat (n)
		begin
			@(posedge clock);
			#1;
		end
	endtask

	task automatic sendRandom(input int n);
		for (int k = 0; k < n; k++)
			sendPair(randOperand(), randOperand());
	endtask

	// gives up after a bounded wait so that lost products show up as leftovers.
	task automatic drainPipe();
		int waited;
		opValid = 1'b0;
		waited  = 0;
		while (expected.size() > 0 && waited < DrainLimit)
		begin
			@(posedge clock);
			#1;
			waited++;
		end
	endtask

	initial
	begin
		clock = 1'b0;
		forever
			#(ClockPeriod / 2) clock = ~clock;
	end

	// resReady is either held high or a coin flip per cycle.
	initial
	begin
		logic [31:0] readyState;
		readyState = 32'h1c7798ea;
		resReady   = 1'b1;
		forever
		begin
			@(posedge clock);
			#1;
			readyState = lfsrStep(readyState);
			resReady   = randomReady ? readyState[0] : 1'b1;
		end
	end

	// model and port checks are sampled mid-cycle where everything is settled.
	always @(negedge clock)
	begin
		logic [ProductW-1:0] want;
		int                  lat;
		cycle = cycle + 1;
		if (!arstN)
		begin
			if (resValid !== 1'b0)
				logError($sformatf("CHECK FAILED resValid expected %h actual %h", 1'b0, resValid));
			expected.delete();  // items in flight are gone.
			acceptedAt.delete();
			holding = 1'b0;
		end
		else
		begin
			if (holding && resValid !== 1'b1)
				logError("resValid dropped before the product was taken");
			else if (holding && product !== heldProduct)
				logError($sformatf("CHECK FAILED product expected %h actual %h", heldProduct, product));
			holding     = resValid && !resReady;
			heldProduct = product;
			if (opValid && opReady)
			begin
				expected.push_back(ProductW'(opA) * ProductW'(opB));
				acceptedAt.push_back(cycle);
				acceptCount++;
			end
			if (resValid && resReady)
			begin
				resultCount++;
				if (expected.size() == 0)
					logError("a product came out with no operand pair waiting in the model");
				else
				begin
					want = expected.pop_front();
					lat  = cycle - acceptedAt.pop_front();
					if (product !== want)
						logError($sformatf("CHECK FAILED product expected %h actual %h", want, product));
					if (checkLatency && lat != 3)
						logError($sformatf("a product took %0d cycles instead of 3", lat));
				end
			end
		end
	end

	initial
	begin
		#((TotalOps * 20 + ResetCycles) * ClockPeriod);
		$display("timeout: the tests did not finish in the expected time");
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial
	begin
		int a0;
		int r0;
		edgeVals     = '{12'h000, 12'hfff, 12'h007, 12'h038, 12'h1c0, 12'he00};
		stimState    = 32'h1c7798ea;
		arstN        = 1'b0;
		opValid      = 1'b0;
		opA          = '0;
		opB          = '0;
		randomReady  = 1'b0;
		checkLatency = 1'b0;
		holding      = 1'b0;
		heldProduct  = '0;
		cycle        = 0;
		errors       = 0;
		acceptCount  = 0;
		resultCount  = 0;
		repeat (ResetCycles) @(posedge clock);
		#1;
		arstN = 1'b1;

		sendRandom(2000);
		drainPipe();

		// every lookup entry lands in every digit position.
		for (int d = 0; d < 8; d++)
			for (int e = 0; e < 8; e++)
				sendPair({NumDigits{d[2:0]}}, {NumDigits{e[2:0]}});
		foreach (edgeVals[x])
			foreach (edgeVals[y])
				sendPair(edgeVals[x], edgeVals[y]);
		drainPipe();

		randomReady = 1'b1;  // back-pressure.
		sendRandom(1000);
		drainPipe();
		randomReady = 1'b0;
		idleCycles(2);

		checkLatency = 1'b1;
		sendRandom(50);
		drainPipe();
		checkLatency = 1'b0;

		// bursts with random gaps.
		randomReady = 1'b1;
		a0 = acceptCount;
		r0 = resultCount;
		for (int k = 0; k < 300; k++)
		begin
			idleCycles(int'({nextBit(), nextBit()}));
			sendPair(randOperand(), randOperand());
		end
		drainPipe();
		if (resultCount - r0 != acceptCount - a0)
			logError($sformatf("CHECK FAILED product count expected %h actual %h",
				acceptCount - a0, resultCount - r0));
		randomReady = 1'b0;
		idleCycles(2);

		sendRandom(6);
		arstN = 1'b0;  // reset with items in flight.
		idleCycles(3);
		arstN = 1'b1;
		idleCycles(4);
		sendRandom(25);
		drainPipe();

		if (expected.size() != 0)
			logError($sformatf("%0d operand pairs never produced a product", expected.size()));
		$display("errors %0d, operand pairs %0d, products %0d", errors, acceptCount, resultCount);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
